/* rtl/ram_consts.svh */
// Memory geometry and timing constants for the RAM exerciser.
// Include in any file that sizes or times the word memory.

`ifndef RAM_CONSTS_SVH
`define RAM_CONSTS_SVH

// Word address bits decoded from byte address bits 9:2.
`define RAM_ADDR_BITS 8

// Words in the array, one per decoded address.
`define RAM_DEPTH 256

// Wait cycles from enable rise to ACCESS. Must be at least 1.
`define RAM_WAIT 2

`endif

/* rtl/cpu_types_pkg.sv */
// Types seen on the CPU side of the RAM port.
// Referenced by scoped name from the interface and the controller.

`default_nettype none

package cpu_types_pkg;

  // One data word.
  typedef logic [31:0] word_t;

  // Byte address, the word index sits in bits 9:2.
  typedef logic [31:0] addr_t;

  // RAM handshake state as reported by the memory.
  typedef enum logic [1:0] {
    FREE   = 2'b00, // No enable high.
    BUSY   = 2'b01, // Enable high, wait not over.
    ACCESS = 2'b10  // Access completes on the next edge.
  } ramstate_t;

endpackage

`default_nettype wire

/* rtl/board_pkg.sv */
// Types for the board I/O of the DE2-style exerciser.
// Covers the seven-segment displays, hex digits and LED banks.

`default_nettype none

package board_pkg;

  // Active-low segments, bit 0 is segment a.
  typedef logic [6:0] seg7_t;

  typedef logic [3:0] nibble_t;

  typedef logic [17:0] ledr_t; // Red LEDs.

  typedef logic [8:0] ledg_t; // Green LEDs.

endpackage

`default_nettype wire

/* rtl/cpu_ram_if.sv */
// RAM port between the access controller and the word memory.
// The controller holds an enable until the memory reports ACCESS
// for one cycle, and drops it on the following edge.

`timescale 1ns/1ps
`default_nettype none

interface cpu_ram_if;

  logic                      ram_wen;
  logic                      ram_ren;
  cpu_types_pkg::addr_t      ram_addr;
  cpu_types_pkg::word_t      ram_store;
  cpu_types_pkg::word_t      ram_load;
  cpu_types_pkg::ramstate_t  ram_state;

  modport ctrl (
    output ram_wen,
    output ram_ren,
    output ram_addr,
    output ram_store,
    input  ram_load,
    input  ram_state
  );

  modport mem (
    input  ram_wen,
    input  ram_ren,
    input  ram_addr,
    input  ram_store,
    output ram_load,
    output ram_state
  );

endinterface

`default_nettype wire

/* rtl/wait_timer.sv */
// Wait-state timer for the word memory.
// A start pulse loads the count, done pulses for one cycle RAM_WAIT
// cycles after the cycle in which start was high.

`timescale 1ns/1ps
`default_nettype none

`include "ram_consts.svh"

module wait_timer (
  input  logic CLOCK_50,
  input  logic rst,
  input  logic start,
  output logic done
);

  localparam int CW = $clog2(`RAM_WAIT + 1);

  logic [CW-1:0] count;
  logic          running;

  always_ff @(posedge CLOCK_50)
  begin
    if (rst)
    begin
      running <= 1'b0;
      count   <= '0;
    end
    else if (start)
    begin
      running <= 1'b1;
      count   <= CW'(`RAM_WAIT - 1); // Zero is the last wait cycle.
    end
    else if (running)
    begin
      if (count == '0)
        running <= 1'b0;
      else
        count <= count - 1'b1;
    end
  end

  assign done = running && (count == '0);

  a_no_restart: assert property (@(posedge CLOCK_50) disable iff (rst)
    start |-> !running);

endmodule

`default_nettype wire

/* rtl/ram_array.sv */
// Word memory behind the RAM port, with a fixed number of wait states.
// The first cycle of an enable starts the timer, the state stays BUSY
// until the timer ends and then reads ACCESS for one cycle.
// Writes land on the edge that closes the ACCESS cycle.

`timescale 1ns/1ps
`default_nettype none

`include "ram_consts.svh"

module ram_array (
  input  logic    CLOCK_50,
  input  logic    rst,
  cpu_ram_if.mem  ram
);

  cpu_types_pkg::word_t          mem [`RAM_DEPTH];
  cpu_types_pkg::word_t          load_q;
  logic [`RAM_ADDR_BITS-1:0]     idx;
  logic                          en;
  logic                          en_q;
  logic                          start;
  logic                          done;

  assign idx   = ram.ram_addr[`RAM_ADDR_BITS+1:2]; // Word select.
  assign en    = ram.ram_wen | ram.ram_ren;
  assign start = en & ~en_q;

  always_ff @(posedge CLOCK_50)
  begin
    if (rst)
      en_q <= 1'b0;
    else
      en_q <= en;
  end

  wait_timer u_wait (
    .CLOCK_50 (CLOCK_50),
    .rst      (rst),
    .start    (start),
    .done     (done)
  );

  always_ff @(posedge CLOCK_50)
  begin
    if (ram.ram_wen && done)
      mem[idx] <= ram.ram_store;
    if (ram.ram_ren && !ram.ram_wen)
      load_q <= mem[idx]; // Settled by the ACCESS cycle.
  end

  assign ram.ram_load  = load_q;
  assign ram.ram_state = !en  ? cpu_types_pkg::FREE :
                         done ? cpu_types_pkg::ACCESS : cpu_types_pkg::BUSY;

  a_addr_held: assert property (@(posedge CLOCK_50) disable iff (rst)
    (ram.ram_state == cpu_types_pkg::BUSY) |=> $stable(ram.ram_addr));

endmodule

`default_nettype wire

/* rtl/ram_ctrl.sv */
// Access controller for the board exerciser.
// key_n[0] requests a write of sw[7:0] to address sw[15:8], key_n[1] a read.
// A read result is held in shown until the next read completes.
// ledg[0] is busy, ledg[1] pulses for one cycle as each access completes.

`timescale 1ns/1ps
`default_nettype none

`include "ram_consts.svh"

module ram_ctrl (
  input  logic                  CLOCK_50,
  input  logic                  rst,
  input  logic [1:0]            key_n,
  input  logic [15:0]           sw,
  cpu_ram_if.ctrl               ram,
  output cpu_types_pkg::word_t  shown,
  output board_pkg::ledg_t      ledg
);

  typedef enum logic [1:0] {IDLE, WRITE, READ} ctrl_state_t;

  ctrl_state_t           state;
  logic [1:0]            key_s1;
  logic [1:0]            key_s2;
  logic [1:0]            key_q;
  logic [1:0]            press;
  logic                  done_q;
  cpu_types_pkg::addr_t  addr_q;
  cpu_types_pkg::word_t  store_q;

  assign press = key_q & ~key_s2; // High to low on the synced key.

  always_ff @(posedge CLOCK_50)
  begin
    if (rst)
    begin
      key_s1 <= 2'b11; // Buttons idle high.
      key_s2 <= 2'b11;
      key_q  <= 2'b11;
      state  <= IDLE;
      shown  <= '0;
      done_q <= 1'b0;
    end
    else
    begin
      key_s1 <= key_n;
      key_s2 <= key_s1;
      key_q  <= key_s2;
      done_q <= 1'b0;
      case (state)
        IDLE:
        begin
          if (press[0])
            state <= WRITE; // Write wins a tie.
          else if (press[1])
            state <= READ;
        end
        WRITE:
        begin
          if (ram.ram_state == cpu_types_pkg::ACCESS)
          begin
            state  <= IDLE;
            done_q <= 1'b1;
          end
        end
        READ:
        begin
          if (ram.ram_state == cpu_types_pkg::ACCESS)
          begin
            state  <= IDLE;
            shown  <= ram.ram_load;
            done_q <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Operands are captured only when a press is accepted.
  always_ff @(posedge CLOCK_50)
  begin
    if (state == IDLE && (|press))
    begin
      addr_q  <= {22'b0, sw[15:8], 2'b00};
      store_q <= {24'b0, sw[7:0]};
    end
  end

  assign ram.ram_wen   = (state == WRITE);
  assign ram.ram_ren   = (state == READ);
  assign ram.ram_addr  = addr_q;
  assign ram.ram_store = store_q;

  assign ledg = {7'b0, done_q, state != IDLE};

  // The memory answers RAM_WAIT cycles after an enable rises.
  a_access_time: assert property (@(posedge CLOCK_50) disable iff (rst)
    $rose(ram.ram_wen || ram.ram_ren) |->
      ##(`RAM_WAIT) (ram.ram_state == cpu_types_pkg::ACCESS));

endmodule

`default_nettype wire

/* rtl/hex_display.sv */
// Shows a 32-bit word as eight hex digits on active-low seven-segment displays.
// hex[0] carries the lowest nibble.

`timescale 1ns/1ps
`default_nettype none

module hex_display (
  input  cpu_types_pkg::word_t  value,
  output board_pkg::seg7_t      hex [7:0]
);

  // Segment order is gfedcba, a lit segment is 0.
  function automatic board_pkg::seg7_t seg_decode(input board_pkg::nibble_t d);
    board_pkg::seg7_t s;
    case (d)
      4'h0: s = 7'b1000000;
      4'h1: s = 7'b1111001;
      4'h2: s = 7'b0100100;
      4'h3: s = 7'b0110000;
      4'h4: s = 7'b0011001;
      4'h5: s = 7'b0010010;
      4'h6: s = 7'b0000010;
      4'h7: s = 7'b1111000;
      4'h8: s = 7'b0000000;
      4'h9: s = 7'b0010000;
      4'ha: s = 7'b0001000;
      4'hb: s = 7'b0000011;
      4'hc: s = 7'b0100111;
      4'hd: s = 7'b0100001;
      4'he: s = 7'b0000110;
      default: s = 7'b0001110; // F.
    endcase
    return s;
  endfunction

  always_comb
  begin
    for (int i = 0; i < 8; i++)
      hex[i] = seg_decode(value[4*i +: 4]);
  end

endmodule

`default_nettype wire

/* rtl/ram_fpga.sv */
// Board top level of the RAM exerciser.
// KEY0 writes SW[7:0] to word SW[15:8], KEY1 reads that word back.
// The last word read appears on HEX7..HEX0, LEDR follows the switches.
// LEDG0 is busy and LEDG1 flashes once per completed access.

`timescale 1ns/1ps
`default_nettype none

module ram_fpga (
  input  logic        CLOCK_50,
  input  logic        rst,
  input  logic [1:0]  key,
  input  logic [17:0] sw,
  output logic [17:0] ledr,
  output logic [8:0]  ledg,
  output logic [6:0]  hex0,
  output logic [6:0]  hex1,
  output logic [6:0]  hex2,
  output logic [6:0]  hex3,
  output logic [6:0]  hex4,
  output logic [6:0]  hex5,
  output logic [6:0]  hex6,
  output logic [6:0]  hex7
);

  cpu_ram_if             ramif ();
  cpu_types_pkg::word_t  shown;
  board_pkg::seg7_t      hex [7:0];

  ram_ctrl u_ctrl (
    .CLOCK_50 (CLOCK_50),
    .rst      (rst),
    .key_n    (key),
    .sw       (sw[15:0]),
    .ram      (ramif.ctrl),
    .shown    (shown),
    .ledg     (ledg)
  );

  ram_array u_ram (
    .CLOCK_50 (CLOCK_50),
    .rst      (rst),
    .ram      (ramif.mem)
  );

  hex_display u_hex (
    .value (shown),
    .hex   (hex)
  );

  assign ledr = board_pkg::ledr_t'(sw);

  assign hex0 = hex[0];
  assign hex1 = hex[1];
  assign hex2 = hex[2];
  assign hex3 = hex[3];
  assign hex4 = hex[4];
  assign hex5 = hex[5];
  assign hex6 = hex[6];
  assign hex7 = hex[7];

endmodule

`default_nettype wire

/* verif/ram_checker.sv */
// Monitor for the RAM exerciser board top level.
// Decodes the eight displays, times busy against the key presses and counts
// done pulses. The testbench pulses check_stb with the expected display word
// and the number of accesses that should have completed by then.

`timescale 1ns/1ps
`default_nettype none

`include "ram_consts.svh"

module ram_checker (
  input  logic        clk,
  input  logic        rst,
  input  logic [1:0]  key,
  input  logic [17:0] sw,
  input  logic [17:0] ledr,
  input  logic [8:0]  ledg,
  input  logic [6:0]  hex0,
  input  logic [6:0]  hex1,
  input  logic [6:0]  hex2,
  input  logic [6:0]  hex3,
  input  logic [6:0]  hex4,
  input  logic [6:0]  hex5,
  input  logic [6:0]  hex6,
  input  logic [6:0]  hex7,
  input  logic        check_stb,
  input  logic [31:0] exp_word,
  input  int          exp_access,
  output int          errors,
  output int          checks
);

  // Two synchronizer cycles, one edge cycle, the wait and the closing edge.
  localparam int LATENCY = 3 + `RAM_WAIT + 1;

  int         cycle;
  int         fall_cycle;
  int         done_count;
  logic       armed; // A press is waiting for its access to finish.
  logic       busy_q;
  logic       done_q;
  logic [1:0] key_q;

  // Active low, gfedcba order. Bit 4 flags a pattern that is no digit.
  function automatic logic [4:0] seg_value(input logic [6:0] s);
    case (s)
      7'b1000000: return 5'h00;
      7'b1111001: return 5'h01;
      7'b0100100: return 5'h02;
      7'b0110000: return 5'h03;
      7'b0011001: return 5'h04;
      7'b0010010: return 5'h05;
      7'b0000010: return 5'h06;
      7'b1111000: return 5'h07;
      7'b0000000: return 5'h08;
      7'b0010000: return 5'h09;
      7'b0001000: return 5'h0a;
      7'b0000011: return 5'h0b;
      7'b0100111: return 5'h0c; // Lower case c.
      7'b0100001: return 5'h0d;
      7'b0000110: return 5'h0e;
      7'b0001110: return 5'h0f;
      default:    return 5'h10;
    endcase
  endfunction

  task automatic compare_display(input logic [31:0] want);
    logic [55:0] segs;
    logic [31:0] got;
    logic [4:0]  v;
    int          i;
    segs = {hex7, hex6, hex5, hex4, hex3, hex2, hex1, hex0};
    got  = '0;
    for (i = 0; i < 8; i++)
    begin
      v = seg_value(segs[7*i +: 7]);
      if (v[4])
      begin
        errors++;
        $display("Fail %0t: digit %0d shows pattern %b", $time, i, segs[7*i +: 7]);
      end
      got[4*i +: 4] = v[3:0];
    end
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("Fail %0t: display shows %h, expected %h", $time, got, want);
    end
  endtask

  initial
  begin
    errors = 0;
    checks = 0;
    cycle  = 0;
  end

  always @(negedge clk)
  begin
    cycle++;
    if (ledr !== sw)
    begin
      errors++;
      $display("Fail %0t: ledr %h, expected %h", $time, ledr, sw);
    end
    if (rst)
    begin
      armed      = 1'b0;
      busy_q     = 1'b0;
      done_q     = 1'b0;
      key_q      = 2'b11;
      done_count = 0;
    end
    else
    begin
      if (!armed && !ledg[0] && ((key_q & ~key) != 2'b00))
      begin
        armed      = 1'b1;
        fall_cycle = cycle;
      end
      if (busy_q && !ledg[0])
      begin
        checks++;
        if (!armed || cycle - fall_cycle != LATENCY)
        begin
          errors++;
          $display("Fail %0t: busy fell %0d cycles after the key, expected %0d",
                   $time, cycle - fall_cycle, LATENCY);
        end
        if (!ledg[1])
        begin
          errors++;
          $display("Fail %0t: done low as busy fell", $time);
        end
        armed = 1'b0;
      end
      if (ledg[1] && done_q)
      begin
        errors++;
        $display("Fail %0t: done high for more than one cycle", $time);
      end
      if (ledg[1] && !done_q)
        done_count++;
      if (check_stb)
      begin
        compare_display(exp_word);
        checks++;
        // All green LEDs are dark between accesses.
        if (done_count != exp_access || ledg !== 9'h000)
        begin
          errors++;
          $display("Fail %0t: %0d accesses done, expected %0d, ledg %b", $time,
                   done_count, exp_access, ledg);
        end
      end
      busy_q = ledg[0];
      done_q = ledg[1];
      key_q  = key;
    end
  end

endmodule

`default_nettype wire

/* verif/tb_ram_fpga.sv */
// Testbench for the RAM exerciser board top level.
// Reads one operation per line from verif/ram_testdata.txt, sets the switches,
// presses the keys and hands the expected display word to ram_checker.
// Kinds X and Y add a press of the other key while the access is busy.

`timescale 1ns/1ps
`default_nettype none

module tb_ram_fpga;

  localparam int CLK_PERIOD    = 20;
  localparam int RESET_CYCLES  = 4;
  localparam int CYCLES_PER_OP = 40;

  logic        clk;
  logic        rst;
  logic [1:0]  key;
  logic [17:0] sw;
  logic [17:0] ledr;
  logic [8:0]  ledg;
  logic [6:0]  hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7;
  logic        check_stb;
  logic [31:0] exp_word;
  int          exp_access;
  int          errors;
  int          checks;
  int          tb_errors;
  int          accepted; // Presses that should have started an access.
  bit          loaded;

  logic [7:0]  op_kind [$];
  logic [7:0]  op_addr [$];
  logic [7:0]  op_data [$];
  logic [31:0] op_exp [$];

  ram_fpga u_dut (
    .CLOCK_50 (clk),
    .rst      (rst),
    .key      (key),
    .sw       (sw),
    .ledr     (ledr),
    .ledg     (ledg),
    .hex0     (hex0),
    .hex1     (hex1),
    .hex2     (hex2),
    .hex3     (hex3),
    .hex4     (hex4),
    .hex5     (hex5),
    .hex6     (hex6),
    .hex7     (hex7)
  );

  ram_checker u_check (
    .clk        (clk),
    .rst        (rst),
    .key        (key),
    .sw         (sw),
    .ledr       (ledr),
    .ledg       (ledg),
    .hex0       (hex0),
    .hex1       (hex1),
    .hex2       (hex2),
    .hex3       (hex3),
    .hex4       (hex4),
    .hex5       (hex5),
    .hex6       (hex6),
    .hex7       (hex7),
    .check_stb  (check_stb),
    .exp_word   (exp_word),
    .exp_access (exp_access),
    .errors     (errors),
    .checks     (checks)
  );

  initial clk = 1'b0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic load_ops();
    int         fd;
    int         n;
    int         ch;
    bit         more;
    logic [7:0] kind;
    logic [7:0] a;
    logic [7:0] d;
    logic [31:0] e;
    fd = $fopen("verif/ram_testdata.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open verif/ram_testdata.txt");
      tb_errors++;
      return;
    end
    more = 1'b1;
    while (more)
    begin
      n = $fscanf(fd, " %c", kind);
      if (n != 1)
        more = 1'b0;
      else if (kind == "#")
      begin
        ch = $fgetc(fd); // Skip the rest of a comment line.
        while (ch != 10 && ch != -1)
          ch = $fgetc(fd);
      end
      else
      begin
        n = $fscanf(fd, "%h %h %h", a, d, e);
        if (n != 3 || !(kind inside {"W", "R", "X", "Y"}))
        begin
          $display("Bad line in test data after %0d operations", op_kind.size());
          tb_errors++;
          more = 1'b0;
        end
        else
        begin
          op_kind.push_back(kind);
          op_addr.push_back(a);
          op_data.push_back(d);
          op_exp.push_back(e);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic send_check(input logic [31:0] word);
    @(posedge clk);
    exp_word   <= word;
    exp_access <= accepted;
    check_stb  <= 1'b1;
    @(posedge clk);
    check_stb  <= 1'b0;
  endtask

  task automatic run_op(input int idx);
    int         main_bit;
    int         stray_at;
    int         c;
    int         guard;
    logic [1:0] k;
    main_bit = (op_kind[idx] inside {"W", "X"}) ? 0 : 1;
    stray_at = (op_kind[idx] == "X") ? 1 : (op_kind[idx] == "Y") ? 2 : -1;
    @(posedge clk);
    sw <= {idx[1:0], op_addr[idx], op_data[idx]};
    for (c = 0; c <= 6; c++)
    begin
      @(posedge clk);
      k = 2'b11;
      if (c < 3)
        k[main_bit] = 1'b0; // Held low for three cycles.
      if (stray_at >= 0 && c >= stray_at && c < stray_at + 3)
        k[1 - main_bit] = 1'b0;
      key <= k;
    end
    accepted++;
    guard = 0;
    @(negedge clk);
    while (ledg[0] && guard < CYCLES_PER_OP)
    begin
      @(negedge clk);
      guard++;
    end
    if (guard == CYCLES_PER_OP)
    begin
      $display("Busy stayed high after operation %0d", idx);
      tb_errors++;
    end
    send_check(op_exp[idx]);
  endtask

  initial
  begin
    rst        = 1'b1;
    key        = 2'b11;
    sw         = '0;
    check_stb  = 1'b0;
    exp_word   = '0;
    exp_access = 0;
    tb_errors  = 0;
    accepted   = 0;
    load_ops();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    send_check(32'h0); // All zeros straight after reset.
    for (int i = 0; i < op_kind.size(); i++)
      run_op(i);
    repeat (4) @(posedge clk);
    $display("Result: %0d operations, %0d checks, %0d errors", op_kind.size(), checks,
             errors + tb_errors);
    if (errors + tb_errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin
    wait (loaded);
    #(CLK_PERIOD * (RESET_CYCLES + 10 + CYCLES_PER_OP * op_kind.size()));
    $display("Timeout, the run did not finish in the time allowed for %0d operations",
             op_kind.size());
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/ram_testdata.txt */
# kind addr data expected_display, all hex
# W write, R read, X write plus stray read press, Y read plus stray write press
W 12 a5 00000000
R 12 00 000000a5
W 00 11 000000a5
W 01 22 000000a5
W 02 33 000000a5
W 03 88 000000a5
W 40 77 000000a5
W 7f 66 000000a5
W 80 44 000000a5
W ff 55 000000a5
R ff 00 00000055
R 00 00 00000011
R 80 00 00000044
R 02 00 00000033
R 7f 00 00000066
R 01 00 00000022
R 40 00 00000077
R 03 00 00000088
R 12 00 000000a5
W 80 c3 000000a5
R 80 00 000000c3
W 00 3c 000000c3
R 00 00 0000003c
R ff 00 00000055
W 54 a5 00000055
W 55 ff 00000055
W aa 5a 00000055
R 55 00 000000ff
R 54 00 000000a5
R aa 00 0000005a
W 55 00 0000005a
R 55 00 00000000
X 20 9e 00000000
R 20 00 0000009e
Y 20 01 0000009e
R 20 00 0000009e
Y ff 00 00000055
R ff 00 00000055
R 80 00 000000c3
X 21 e7 000000c3
R 21 00 000000e7
R 20 00 0000009e

/* verilog.f */
+incdir+rtl
rtl/cpu_types_pkg.sv
rtl/board_pkg.sv
rtl/cpu_ram_if.sv
rtl/wait_timer.sv
rtl/ram_array.sv
rtl/ram_ctrl.sv
rtl/hex_display.sv
rtl/ram_fpga.sv
verif/ram_checker.sv
verif/tb_ram_fpga.sv
